/* design/bus_arbiter.sv */
// ==================================================
// two-host round-robin arbiter, grant held for cyc
// bus is free again one cycle after the owner drops cyc
// ==================================================
`default_nettype none

module bus_arbiter
  import mini_mcu_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,
  input  wb_req_t host0_req_i,
  input  wb_req_t host1_req_i,
  output wb_rsp_t host0_rsp_o,
  output wb_rsp_t host1_rsp_o,
  output wb_req_t bus_req_o,
  input  wb_rsp_t bus_rsp_i
);

  arb_state_e state_q;
  arb_state_e state_d;
  logic       last_q;  // set when host 1 had the last grant
  logic       own0;
  logic       own1;

  // ownership, combinational grant out of idle
  always_comb begin
    own0 = 1'b0;
    own1 = 1'b0;
    case (state_q)
      grant0: own0 = 1'b1;
      grant1: own1 = 1'b1;
      default: begin
        if (host0_req_i.cyc && host1_req_i.cyc) begin
          own0 = last_q;
          own1 = !last_q;
        end else begin
          own0 = host0_req_i.cyc;
          own1 = host1_req_i.cyc;
        end
      end
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      idle: begin
        if (own0) begin
          state_d = grant0;
        end else if (own1) begin
          state_d = grant1;
        end
      end
      grant0: if (!host0_req_i.cyc) state_d = idle;
      grant1: if (!host1_req_i.cyc) state_d = idle;
      default: state_d = idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= idle;
      last_q  <= 1'b1;
    end else begin
      state_q <= state_d;
      if (state_q == idle && (own0 || own1)) begin
        last_q <= own1;
      end
    end
  end

  assign bus_req_o = own0 ? host0_req_i : (own1 ? host1_req_i : '0);

  // only the owner sees ack and err
  always_comb begin
    host0_rsp_o = bus_rsp_i;
    host1_rsp_o = bus_rsp_i;
    if (!own0) begin
      host0_rsp_o.ack = 1'b0;
      host0_rsp_o.err = 1'b0;
    end
    if (!own1) begin
      host1_rsp_o.ack = 1'b0;
      host1_rsp_o.err = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* design/core_v_mini_mcu.sv */
// ==================================================
// mini MCU top, two external Wishbone hosts
// no CPU, debug or pads; GPIO split into in/out/en
// ==================================================
`default_nettype none

module core_v_mini_mcu
  import mini_mcu_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,
  input  wb_req_t host0_req_i,
  input  wb_req_t host1_req_i,
  output wb_rsp_t host0_rsp_o,
  output wb_rsp_t host1_rsp_o,
  input  data_t   gpio_i,
  output data_t   gpio_o,
  output data_t   gpio_en_o,
  output data_t   exit_value_o,
  output logic    exit_valid_o
);

  // granted host towards the decoder
  wb_req_t bus_req;
  wb_rsp_t bus_rsp;

  // decoder towards the slaves
  wb_req_t ram_req;
  wb_rsp_t ram_rsp;
  wb_req_t periph_req;
  wb_rsp_t periph_rsp;

  bus_arbiter bus_arbiter_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .host0_req_i(host0_req_i),
    .host1_req_i(host1_req_i),
    .host0_rsp_o(host0_rsp_o),
    .host1_rsp_o(host1_rsp_o),
    .bus_req_o  (bus_req),
    .bus_rsp_i  (bus_rsp)
  );

  system_bus system_bus_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .bus_req_i   (bus_req),
    .bus_rsp_o   (bus_rsp),
    .ram_req_o   (ram_req),
    .ram_rsp_i   (ram_rsp),
    .periph_req_o(periph_req),
    .periph_rsp_i(periph_rsp)
  );

  memory_subsystem memory_subsystem_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .ram_req_i(ram_req),
    .ram_rsp_o(ram_rsp)
  );

  peripheral_subsystem peripheral_subsystem_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .periph_req_i(periph_req),
    .periph_rsp_o(periph_rsp),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_en_o   (gpio_en_o),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o)
  );

endmodule

`default_nettype wire

/* design/memory_subsystem.sv */
// ==================================================
// word RAM, byte writes, ack one cycle after stb
// contents are undefined after power-up
// ==================================================
`default_nettype none

`include "mini_mcu_cfg.svh"

module memory_subsystem
  import mini_mcu_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,
  input  wb_req_t ram_req_i,
  output wb_rsp_t ram_rsp_o
);

  localparam int words = `MCU_RAM_BYTES / 4;
  localparam int idx_w = $clog2(words);
  localparam addr_t ram_base = `MCU_RAM_BASE;

  data_t             mem[words];
  addr_t             word_off;
  logic [idx_w-1:0]  word_idx;
  logic              access;
  logic              ack_q;
  data_t             rd_q;

  assign word_off = ram_req_i.adr - ram_base;
  assign word_idx = word_off[idx_w+1:2];
  assign access   = ram_req_i.cyc && ram_req_i.stb && !ack_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rd_q <= mem[word_idx];
      if (ram_req_i.we) begin
        mem[word_idx] <= byte_merge(mem[word_idx], ram_req_i.dat, ram_req_i.sel);
      end
    end
  end

  assign ram_rsp_o.ack = ack_q;
  assign ram_rsp_o.err = 1'b0;
  assign ram_rsp_o.dat = rd_q;

endmodule

`default_nettype wire

/* design/mini_mcu_cfg.svh */
// ==================================================
// widths, RAM size and address map of the mini MCU
// windows must be aligned to their own size
// ==================================================
`ifndef MINI_MCU_CFG_SVH
`define MINI_MCU_CFG_SVH

// bus widths
`define MCU_DATA_W 32
`define MCU_ADDR_W 32

// on-chip RAM, word organized
`define MCU_RAM_BYTES 1024
`define MCU_RAM_BASE 32'h0000_0000

// peripheral window, four word registers
`define MCU_PERIPH_BASE 32'h2000_0000
`define MCU_PERIPH_BYTES 16

`endif

/* design/mini_mcu_pkg.sv */
// ==================================================
// shared bus types, Wishbone classic only
// ==================================================
`default_nettype none

`include "mini_mcu_cfg.svh"

package mini_mcu_pkg;

  typedef logic [`MCU_DATA_W-1:0] data_t;
  typedef logic [`MCU_ADDR_W-1:0] addr_t;
  typedef logic [`MCU_DATA_W/8-1:0] sel_t;

  // host to slave
  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    sel_t  sel;
    addr_t adr;
    data_t dat;
  } wb_req_t;

  // slave to host
  typedef struct packed {
    logic  ack;
    logic  err;
    data_t dat;
  } wb_rsp_t;

  typedef enum logic [1:0] {
    idle,
    grant0,
    grant1
  } arb_state_e;

  // replaces the bytes of old_w whose sel bit is set
  function automatic data_t byte_merge(data_t old_w, data_t new_w, sel_t sel);
    data_t merged;
    merged = old_w;
    for (int b = 0; b < `MCU_DATA_W / 8; b++) begin
      if (sel[b]) begin
        merged[8*b+:8] = new_w[8*b+:8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

/* design/peripheral_subsystem.sv */
// ==================================================
// GPIO out/en/in and exit registers, word offsets
// gpio_i is synchronized, reads see it two cycles late
// ==================================================
`default_nettype none

`include "mini_mcu_cfg.svh"

module peripheral_subsystem
  import mini_mcu_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,
  input  wb_req_t periph_req_i,
  output wb_rsp_t periph_rsp_o,
  input  data_t   gpio_i,
  output data_t   gpio_o,
  output data_t   gpio_en_o,
  output data_t   exit_value_o,
  output logic    exit_valid_o
);

  localparam addr_t periph_base = `MCU_PERIPH_BASE;
  localparam addr_t periph_size = addr_t'(`MCU_PERIPH_BYTES);

  addr_t      periph_off;
  logic [1:0] reg_idx;
  logic       in_win;
  logic       access;
  logic       wr;
  logic       ack_q;
  logic       err_q;
  data_t      rd_q;
  data_t      gpio_meta_q;
  data_t      gpio_sync_q;

  assign periph_off = periph_req_i.adr - periph_base;
  assign reg_idx    = periph_off[3:2];
  assign in_win     = periph_off < periph_size;
  assign access     = periph_req_i.cyc && periph_req_i.stb && !ack_q && !err_q;
  assign wr         = access && in_win && periph_req_i.we;

  always_ff @(posedge clk_i) begin
    gpio_meta_q <= gpio_i;
    gpio_sync_q <= gpio_meta_q;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q        <= 1'b0;
      err_q        <= 1'b0;
      gpio_o       <= '0;
      gpio_en_o    <= '0;
      exit_value_o <= '0;
      exit_valid_o <= 1'b0;
    end else begin
      ack_q <= access && in_win;
      err_q <= access && !in_win;
      if (wr) begin
        case (reg_idx)
          2'd0: gpio_o <= byte_merge(gpio_o, periph_req_i.dat, periph_req_i.sel);
          2'd1: gpio_en_o <= byte_merge(gpio_en_o, periph_req_i.dat, periph_req_i.sel);
          2'd3: begin
            exit_value_o <= byte_merge(exit_value_o, periph_req_i.dat, periph_req_i.sel);
            exit_valid_o <= 1'b1;
          end
          // gpio_in is read-only
          default: ;
        endcase
      end
    end
  end

  // read data captured on the acknowledging edge
  always_ff @(posedge clk_i) begin
    if (access) begin
      case (reg_idx)
        2'd0: rd_q <= gpio_o;
        2'd1: rd_q <= gpio_en_o;
        2'd2: rd_q <= gpio_sync_q;
        default: rd_q <= exit_value_o;
      endcase
    end
  end

  assign periph_rsp_o.ack = ack_q;
  assign periph_rsp_o.err = err_q;
  assign periph_rsp_o.dat = rd_q;

endmodule

`default_nettype wire

/* design/system_bus.sv */
// ==================================================
// address decoder for RAM and peripheral windows
// unmapped accesses get err one cycle after stb
// ==================================================
`default_nettype none

`include "mini_mcu_cfg.svh"

module system_bus
  import mini_mcu_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,
  input  wb_req_t bus_req_i,
  output wb_rsp_t bus_rsp_o,
  output wb_req_t ram_req_o,
  input  wb_rsp_t ram_rsp_i,
  output wb_req_t periph_req_o,
  input  wb_rsp_t periph_rsp_i
);

  localparam addr_t ram_base = `MCU_RAM_BASE;
  localparam addr_t ram_size = addr_t'(`MCU_RAM_BYTES);
  localparam addr_t periph_base = `MCU_PERIPH_BASE;
  localparam addr_t periph_size = addr_t'(`MCU_PERIPH_BYTES);

  addr_t ram_off;
  addr_t periph_off;
  logic  ram_hit;
  logic  periph_hit;
  logic  unmapped;
  logic  err_q;

  // offset compare avoids a lower bound check
  assign ram_off    = bus_req_i.adr - ram_base;
  assign periph_off = bus_req_i.adr - periph_base;
  assign ram_hit    = ram_off < ram_size;
  assign periph_hit = periph_off < periph_size;
  assign unmapped   = !ram_hit && !periph_hit;

  always_comb begin
    ram_req_o        = bus_req_i;
    ram_req_o.cyc    = bus_req_i.cyc && ram_hit;
    ram_req_o.stb    = bus_req_i.stb && ram_hit;
    periph_req_o     = bus_req_i;
    periph_req_o.cyc = bus_req_i.cyc && periph_hit;
    periph_req_o.stb = bus_req_i.stb && periph_hit;
  end

  // one-shot error, cannot repeat within one strobe
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= bus_req_i.cyc && bus_req_i.stb && unmapped && !err_q;
    end
  end

  always_comb begin
    bus_rsp_o.ack = ram_rsp_i.ack || periph_rsp_i.ack;
    bus_rsp_o.err = ram_rsp_i.err || periph_rsp_i.err || err_q;
    if (ram_hit) begin
      bus_rsp_o.dat = ram_rsp_i.dat;
    end else if (periph_hit) begin
      bus_rsp_o.dat = periph_rsp_i.dat;
    end else begin
      bus_rsp_o.dat = '0;
    end
  end

endmodule

`default_nettype wire

/* dv/tb_mini_mcu.sv */
// ==================================================
// two random Wishbone hosts against a shared model
// RAM traffic stays in the first 16 words; only host 0 moves gpio_i
// ==================================================
`default_nettype none

`include "mini_mcu_cfg.svh"

module tb_mini_mcu
  import mini_mcu_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int accesses = 300;
  localparam int reset_cycles = 8;
  localparam int cycle_limit = 2 * accesses * 8 + reset_cycles;
  localparam logic [31:0] seed = 32'h8e1ae41c;

  logic    clk_i;
  logic    rst_i;
  wb_req_t req[2];
  wb_rsp_t rsp[2];
  data_t   gpio_i;
  data_t   gpio_o;
  data_t   gpio_en_o;
  data_t   exit_value_o;
  logic    exit_valid_o;

  // reference model
  data_t ram_model[16];
  data_t ram_known[16];
  data_t gpio_out_m;
  data_t gpio_en_m;
  data_t exit_value_m;
  logic  exit_valid_m;
  data_t gpio_in_m;

  logic [31:0] rng[2];
  int          start_cyc[2];
  int          done_cyc[2];
  int          must_next;
  int          last_host;
  int          cycle = 0;

  core_v_mini_mcu dut0 (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .host0_req_i (req[0]),
    .host1_req_i (req[1]),
    .host0_rsp_o (rsp[0]),
    .host1_rsp_o (rsp[1]),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_en_o   (gpio_en_o),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle = cycle + 1;
    if (cycle > cycle_limit) begin
      $display("timeout: the run hung, no progress after %0d cycles", cycle);
      $display("Simulation finished: FAIL");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] next_rand(input int h);
    rng[h] = xorshift(rng[h]);
    return rng[h];
  endfunction

  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input sel_t sel);
    data_t w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) w[8*b+:8] = new_w[8*b+:8];
    end
    return w;
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  task automatic check_outputs();
    check_eq(gpio_o, gpio_out_m, "gpio_o");
    check_eq(gpio_en_o, gpio_en_m, "gpio_en_o");
    check_eq(exit_value_o, exit_value_m, "exit_value_o");
    check_eq({31'd0, exit_valid_o}, {31'd0, exit_valid_m}, "exit_valid_o");
  endtask

  // idle cycle in which this host must see no response
  task automatic idle_cycle(input int h);
    @(posedge clk_i);
    #1;
    check_eq({30'd0, rsp[h].ack, rsp[h].err}, 32'd0, "response outside an access");
    #1;
  endtask

  task automatic run_host(input int h);
    int          o;
    int          region;
    int          idx;
    int          waited;
    logic        fast;
    logic [31:0] r;
    wb_req_t     q;
    data_t       exp_rd;
    o = 1 - h;
    for (int n = 0; n < accesses; n++) begin
      r = next_rand(h);
      repeat (1 + int'(r % 3)) idle_cycle(h);
      r = next_rand(h);
      region = int'(r[2:0]);
      q = '0;
      q.cyc = 1'b1;
      q.stb = 1'b1;
      q.we = r[3];
      q.sel = r[7:4];
      q.dat = next_rand(h);
      if (region < 4) begin
        idx = int'(r[11:8]);
        q.adr = `MCU_RAM_BASE | {26'd0, r[11:8], 2'b00};
      end else if (region < 7) begin
        idx = int'(r[9:8]);
        q.adr = `MCU_PERIPH_BASE | {28'd0, r[9:8], 2'b00};
      end else begin
        idx = 0;
        q.adr = 32'h1000_0000 | {4'd0, r[31:6], 2'b00};
      end
      // gpio_in reads need gpio_i settled through the synchronizer
      if (region >= 4 && region < 7 && idx == 2) begin
        if (h == 1) begin
          q.we = 1'b1;
        end else if (!q.we) begin
          gpio_in_m = next_rand(h);
          gpio_i = gpio_in_m;
          repeat (3) idle_cycle(h);
        end
      end
      req[h] = q;
      start_cyc[h] = cycle;
      waited = 0;
      fast = 1'b0;
      do begin
        @(posedge clk_i);
        #1;
        if (waited == 0) begin
          fast = done_cyc[o] >= start_cyc[o] && done_cyc[o] < start_cyc[h];
        end
        if (!(rsp[h].ack || rsp[h].err)) begin
          waited++;
          #1;
        end
      end while (!(rsp[h].ack || rsp[h].err));
      done_cyc[h] = cycle;
      if (fast) check_eq(32'(waited), 32'd0, "latency on an idle bus");
      if (must_next >= 0) check_eq(32'(h), 32'(must_next), "round-robin order");
      // both hosts raised cyc in the same idle cycle
      if (start_cyc[o] == start_cyc[h] && start_cyc[o] > done_cyc[o]) begin
        check_eq(32'(h), 32'(1 - last_host), "round-robin tie");
      end
      last_host = h;
      must_next = (start_cyc[o] > done_cyc[o]) ? o : -1;
      if (region < 4) begin
        check_eq({30'd0, rsp[h].ack, rsp[h].err}, 32'd2, "RAM ack");
        if (q.we) begin
          ram_model[idx] = merge_bytes(ram_model[idx], q.dat, q.sel);
          ram_known[idx] = merge_bytes(ram_known[idx], 32'hffff_ffff, q.sel);
        end else begin
          check_eq(rsp[h].dat & ram_known[idx], ram_model[idx] & ram_known[idx], "RAM read");
        end
      end else if (region < 7) begin
        check_eq({30'd0, rsp[h].ack, rsp[h].err}, 32'd2, "peripheral ack");
        if (q.we) begin
          case (idx)
            0: gpio_out_m = merge_bytes(gpio_out_m, q.dat, q.sel);
            1: gpio_en_m = merge_bytes(gpio_en_m, q.dat, q.sel);
            3: begin
              exit_value_m = merge_bytes(exit_value_m, q.dat, q.sel);
              exit_valid_m = 1'b1;
            end
            default: ;
          endcase
        end else begin
          case (idx)
            0: exp_rd = gpio_out_m;
            1: exp_rd = gpio_en_m;
            2: exp_rd = gpio_in_m;
            default: exp_rd = exit_value_m;
          endcase
          check_eq(rsp[h].dat, exp_rd, "peripheral read");
        end
      end else begin
        check_eq({30'd0, rsp[h].ack, rsp[h].err}, 32'd1, "unmapped err");
        if (!q.we) check_eq(rsp[h].dat, 32'd0, "unmapped read data");
      end
      check_outputs();
      #1;
      req[h] = '0;
    end
  endtask

  initial begin
    rst_i = 1'b1;
    req[0] = '0;
    req[1] = '0;
    gpio_i = '0;
    gpio_in_m = '0;
    gpio_out_m = '0;
    gpio_en_m = '0;
    exit_value_m = '0;
    exit_valid_m = 1'b0;
    rng[0] = seed;
    rng[1] = ~seed;
    must_next = -1;
    // host 1 counts as the last owner after reset
    last_host = 1;
    for (int i = 0; i < 2; i++) begin
      start_cyc[i] = -10;
      done_cyc[i] = -5;
    end
    for (int i = 0; i < 16; i++) begin
      ram_model[i] = '0;
      ram_known[i] = '0;
    end
    repeat (reset_cycles) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    @(posedge clk_i);
    #1;
    check_outputs();
    check_eq({30'd0, rsp[0].ack, rsp[0].err}, 32'd0, "host 0 response after reset");
    check_eq({30'd0, rsp[1].ack, rsp[1].err}, 32'd0, "host 1 response after reset");
    #1;
    fork
      run_host(0);
      run_host(1);
    join
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+design
design/mini_mcu_pkg.sv
design/bus_arbiter.sv
design/system_bus.sv
design/memory_subsystem.sv
design/peripheral_subsystem.sv
design/core_v_mini_mcu.sv
dv/tb_mini_mcu.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the mini MCU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_mini_mcu -f project.f -o tb_mini_mcu

# the simulation may stop with an error, the log decides
./obj_dir/tb_mini_mcu > sim.log 2>&1 || true

if grep -q "Simulation finished: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
